// File: dual_adc_interface.f
rtl/adc_sync_pkg.sv
rtl/adc_sync_sequencer.sv
rtl/adc_lane_capture.sv
rtl/adc_pair_aligner.sv
rtl/dual_adc_interface.sv
tests/dual_adc_checker.sv
tests/dual_adc_interface_tb.sv

// File: rtl/adc_lane_capture.sv
`timescale 1ns/1ns
`default_nettype none

module adc_lane_capture (
	input  wire                       dcm_psclk,
	input  wire                       ctrl_reset,
	input  wire adc_sync_pkg::sample_t data_eveni,
	input  wire adc_sync_pkg::sample_t data_oddi,
	input  wire adc_sync_pkg::sample_t data_evenq,
	input  wire adc_sync_pkg::sample_t data_oddq,
	input  wire                       sync,
	input  wire                       outofrange,
	output adc_sync_pkg::adc_word_t   lane_word,
	output logic                      lane_valid,
	output logic                      lane_sync,
	output logic                      lane_outofrange
);

	logic                  fall_next;	// Next cycle is a fall half
	logic                  is_rise;
	adc_sync_pkg::sample_t rise_i0;
	adc_sync_pkg::sample_t rise_i1;
	adc_sync_pkg::sample_t rise_q0;
	adc_sync_pkg::sample_t rise_q1;
	logic                  rise_sync;
	logic                  rise_oor;

	// Sync forces a rise half and restarts the pairing
	assign is_rise = sync | ~fall_next;

	always_ff @(posedge dcm_psclk) begin
		if (ctrl_reset) begin
			fall_next  <= 1'b0;
			lane_valid <= 1'b0;
		end else begin
			fall_next  <= is_rise;
			lane_valid <= ~is_rise;	// One cycle after the fall half
		end
	end

	// ============================================================
	// Rise half holding and word assembly
	// ============================================================
	always_ff @(posedge dcm_psclk) begin
		if (is_rise) begin
			rise_i0   <= data_eveni;
			rise_i1   <= data_oddi;
			rise_q0   <= data_evenq;
			rise_q1   <= data_oddq;
			rise_sync <= sync;
			rise_oor  <= outofrange;
		end else begin
			lane_word <= {rise_i0, rise_i1, data_eveni, data_oddi,
				rise_q0, rise_q1, data_evenq, data_oddq};
			lane_sync       <= rise_sync | sync;
			lane_outofrange <= rise_oor | outofrange;	// OR over both halves
		end
	end

	a_valid_single: assert property (@(posedge dcm_psclk) disable iff (ctrl_reset)
		lane_valid |=> !lane_valid);

endmodule

`default_nettype wire

// File: rtl/adc_pair_aligner.sv
`timescale 1ns/1ns
`default_nettype none

module adc_pair_aligner (
	input  wire                        dcm_psclk,
	input  wire                        ctrl_reset,
	input  wire adc_sync_pkg::adc_word_t word0,
	input  wire adc_sync_pkg::adc_word_t word1,
	input  wire                        valid0,
	input  wire                        valid1,
	input  wire                        sync0,
	input  wire                        sync1,
	input  wire                        outofrange0,
	input  wire                        outofrange1,
	input  wire                        sync_done,
	output adc_sync_pkg::adc_word_t    user_word0,
	output adc_sync_pkg::adc_word_t    user_word1,
	output logic                       user_data_valid,
	output logic                       user_sync,
	output logic                       user_outofrange
);

	adc_sync_pkg::adc_word_t buf_word0, buf_word1;
	logic                    buf_sync0, buf_sync1;
	logic                    buf_oor0, buf_oor1;
	logic                    full0, full1;
	logic                    have0, have1;
	logic                    release_pair;

	// A word arriving this cycle counts as present
	assign have0        = full0 | valid0;
	assign have1        = full1 | valid1;
	assign release_pair = sync_done & have0 & have1;

	always_ff @(posedge dcm_psclk) begin
		if (ctrl_reset || !sync_done) begin
			full0           <= 1'b0;	// Discard until calibrated
			full1           <= 1'b0;
			user_data_valid <= 1'b0;
		end else begin
			user_data_valid <= release_pair;
			full0           <= release_pair ? 1'b0 : have0;
			full1           <= release_pair ? 1'b0 : have1;
		end
	end

	// ============================================================
	// Word buffers and output pair
	// ============================================================
	always_ff @(posedge dcm_psclk) begin
		if (valid0) begin
			buf_word0 <= word0;	// Newer word overwrites
			buf_sync0 <= sync0;
			buf_oor0  <= outofrange0;
		end
		if (valid1) begin
			buf_word1 <= word1;
			buf_sync1 <= sync1;
			buf_oor1  <= outofrange1;
		end
		if (release_pair) begin
			user_word0      <= valid0 ? word0 : buf_word0;
			user_word1      <= valid1 ? word1 : buf_word1;
			user_sync       <= (valid0 ? sync0 : buf_sync0) | (valid1 ? sync1 : buf_sync1);
			user_outofrange <= (valid0 ? outofrange0 : buf_oor0) |
				(valid1 ? outofrange1 : buf_oor1);
		end
	end

	a_valid_after_done: assert property (@(posedge dcm_psclk) disable iff (ctrl_reset)
		user_data_valid |-> sync_done);

endmodule

`default_nettype wire

// File: rtl/adc_sync_pkg.sv
`default_nettype none

package adc_sync_pkg;

	// ============================================================
	// Sample and word widths
	// ============================================================
	localparam int SAMPLE_W = 8;

	typedef logic [SAMPLE_W-1:0]   sample_t;
	typedef logic [8*SAMPLE_W-1:0] adc_word_t;	// i0 i1 i2 i3 q0 q1 q2 q3, msb first

	// Sampled adc1 clock, bit 0 = 0 deg up to bit 3 = 270 deg
	typedef logic [3:0] phase_bits_t;
	typedef logic [1:0] reset_slot_t;	// Phase slot of the adc1 reset

	// ============================================================
	// Calibration FSM states
	// ============================================================
	typedef enum logic [2:0] {
		st_init          = 3'd0,
		st_reset_adc     = 3'd1,
		st_wait_adc      = 3'd2,
		st_wait_lock     = 3'd3,
		st_sample_clocks = 3'd4,
		st_decide        = 3'd5,
		st_done          = 3'd6
	} seq_state_t;

endpackage

`default_nettype wire

// File: rtl/adc_sync_sequencer.sv
`timescale 1ns/1ns
`default_nettype none

module adc_sync_sequencer #(
	parameter int STARTUP_CYCLES = 20,	// Power-up wait
	parameter int SETTLE_CYCLES  = 8	// Wait after each adc1 reset
) (
	input  wire                        dcm_psclk,
	input  wire                        ctrl_reset,
	input  wire                        adc0_locked,
	input  wire                        adc1_locked,
	input  wire adc_sync_pkg::phase_bits_t clk_phase_bits,
	input  wire                        clk_phase_valid,
	output logic                       adc1_reset,
	output logic                       sample_req,
	output logic                       sync_done,
	output adc_sync_pkg::reset_slot_t  reset_slot
);

	// One counter serves both waits
	localparam int MAX_WAIT = (STARTUP_CYCLES > SETTLE_CYCLES) ? STARTUP_CYCLES : SETTLE_CYCLES;
	localparam int CNT_W    = $clog2(MAX_WAIT + 1);

	adc_sync_pkg::seq_state_t  state;
	adc_sync_pkg::seq_state_t  next_state;
	logic [CNT_W-1:0]          delay_cnt;
	adc_sync_pkg::phase_bits_t phase_q;	// Bits taken with clk_phase_valid
	logic                      phase_ok;

	// Second converter aligned when 90 and 180 deg both read high
	assign phase_ok = phase_q[1] & phase_q[2];

	// ============================================================
	// State register and counters
	// ============================================================
	always_ff @(posedge dcm_psclk) begin
		if (ctrl_reset) begin
			state      <= adc_sync_pkg::st_init;
			delay_cnt  <= '0;
			reset_slot <= '0;
		end else begin
			state <= next_state;
			if (state == adc_sync_pkg::st_init || state == adc_sync_pkg::st_wait_adc) begin
				delay_cnt <= delay_cnt + 1'b1;
			end else begin
				delay_cnt <= '0;
			end
			if (state == adc_sync_pkg::st_decide && !phase_ok) begin
				reset_slot <= reset_slot + 1'b1;	// Next attempt, wraps 3 -> 0
			end
		end
	end

	// Phase answer for the decide state
	always_ff @(posedge dcm_psclk) begin
		if (state == adc_sync_pkg::st_sample_clocks && clk_phase_valid) begin
			phase_q <= clk_phase_bits;
		end
	end

	always_comb begin
		next_state = state;
		case (state)
			adc_sync_pkg::st_init: begin
				if (delay_cnt == CNT_W'(STARTUP_CYCLES - 1)) begin
					next_state = adc_sync_pkg::st_reset_adc;
				end
			end
			adc_sync_pkg::st_reset_adc: begin
				next_state = adc_sync_pkg::st_wait_adc;	// Single pulse
			end
			adc_sync_pkg::st_wait_adc: begin
				if (delay_cnt == CNT_W'(SETTLE_CYCLES - 1)) begin
					next_state = adc_sync_pkg::st_wait_lock;
				end
			end
			adc_sync_pkg::st_wait_lock: begin
				if (adc0_locked && adc1_locked) begin
					next_state = adc_sync_pkg::st_sample_clocks;
				end
			end
			adc_sync_pkg::st_sample_clocks: begin
				if (clk_phase_valid) begin
					next_state = adc_sync_pkg::st_decide;
				end
			end
			adc_sync_pkg::st_decide: begin
				if (phase_ok) begin
					next_state = adc_sync_pkg::st_done;
				end else begin
					next_state = adc_sync_pkg::st_reset_adc;	// Retry on next slot
				end
			end
			adc_sync_pkg::st_done: begin
				next_state = adc_sync_pkg::st_done;
			end
			default: begin
				next_state = adc_sync_pkg::st_init;
			end
		endcase
	end

	assign adc1_reset = (state == adc_sync_pkg::st_reset_adc);
	assign sample_req = (state == adc_sync_pkg::st_sample_clocks);
	assign sync_done  = (state == adc_sync_pkg::st_done);

	// ============================================================
	// Assertions
	// ============================================================
	a_reset_single: assert property (@(posedge dcm_psclk) disable iff (ctrl_reset)
		adc1_reset |=> !adc1_reset);

	a_done_sticky: assert property (@(posedge dcm_psclk) disable iff (ctrl_reset)
		sync_done |=> sync_done);

endmodule

`default_nettype wire

// File: rtl/dual_adc_interface.sv
`timescale 1ns/1ns
`default_nettype none

module dual_adc_interface #(
	parameter int STARTUP_CYCLES = 20,	// 125000000 on hardware
	parameter int SETTLE_CYCLES  = 8	// 2000 on hardware
) (
	input  wire                          dcm_psclk,
	input  wire                          ctrl_reset,
	// ADC0 lane
	input  wire adc_sync_pkg::sample_t   adc0_data_eveni,
	input  wire adc_sync_pkg::sample_t   adc0_data_oddi,
	input  wire adc_sync_pkg::sample_t   adc0_data_evenq,
	input  wire adc_sync_pkg::sample_t   adc0_data_oddq,
	input  wire                          adc0_sync,
	input  wire                          adc0_outofrange,
	// ADC1 lane
	input  wire adc_sync_pkg::sample_t   adc1_data_eveni,
	input  wire adc_sync_pkg::sample_t   adc1_data_oddi,
	input  wire adc_sync_pkg::sample_t   adc1_data_evenq,
	input  wire adc_sync_pkg::sample_t   adc1_data_oddq,
	input  wire                          adc1_sync,
	input  wire                          adc1_outofrange,
	// Calibration
	input  wire                          adc0_locked,
	input  wire                          adc1_locked,
	input  wire adc_sync_pkg::phase_bits_t clk_phase_bits,
	input  wire                          clk_phase_valid,
	output logic                         adc1_reset,
	output adc_sync_pkg::reset_slot_t    reset_slot,
	output logic                         sample_req,
	output logic                         sync_done,
	// User side
	output adc_sync_pkg::adc_word_t      user_word0,
	output adc_sync_pkg::adc_word_t      user_word1,
	output logic                         user_data_valid,
	output logic                         user_sync,
	output logic                         user_outofrange
);

	adc_sync_pkg::adc_word_t lane0_word, lane1_word;
	logic                    lane0_valid, lane1_valid;
	logic                    lane0_sync, lane1_sync;
	logic                    lane0_oor, lane1_oor;

	// ============================================================
	// Calibration and capture
	// ============================================================
	adc_sync_sequencer #(
		.STARTUP_CYCLES(STARTUP_CYCLES),
		.SETTLE_CYCLES (SETTLE_CYCLES)
	) u_sequencer (
		.dcm_psclk      (dcm_psclk),
		.ctrl_reset     (ctrl_reset),
		.adc0_locked    (adc0_locked),
		.adc1_locked    (adc1_locked),
		.clk_phase_bits (clk_phase_bits),
		.clk_phase_valid(clk_phase_valid),
		.adc1_reset     (adc1_reset),
		.sample_req     (sample_req),
		.sync_done      (sync_done),
		.reset_slot     (reset_slot)
	);

	adc_lane_capture u_lane0 (
		.dcm_psclk(dcm_psclk), .ctrl_reset(ctrl_reset),
		.data_eveni(adc0_data_eveni), .data_oddi(adc0_data_oddi),
		.data_evenq(adc0_data_evenq), .data_oddq(adc0_data_oddq),
		.sync(adc0_sync), .outofrange(adc0_outofrange),
		.lane_word(lane0_word), .lane_valid(lane0_valid),
		.lane_sync(lane0_sync), .lane_outofrange(lane0_oor)
	);

	adc_lane_capture u_lane1 (
		.dcm_psclk(dcm_psclk), .ctrl_reset(ctrl_reset),
		.data_eveni(adc1_data_eveni), .data_oddi(adc1_data_oddi),
		.data_evenq(adc1_data_evenq), .data_oddq(adc1_data_oddq),
		.sync(adc1_sync), .outofrange(adc1_outofrange),
		.lane_word(lane1_word), .lane_valid(lane1_valid),
		.lane_sync(lane1_sync), .lane_outofrange(lane1_oor)
	);

	// Pairs are held back until the sequencer reports done
	adc_pair_aligner u_aligner (
		.dcm_psclk      (dcm_psclk),
		.ctrl_reset     (ctrl_reset),
		.word0          (lane0_word),
		.word1          (lane1_word),
		.valid0         (lane0_valid),
		.valid1         (lane1_valid),
		.sync0          (lane0_sync),
		.sync1          (lane1_sync),
		.outofrange0    (lane0_oor),
		.outofrange1    (lane1_oor),
		.sync_done      (sync_done),
		.user_word0     (user_word0),
		.user_word1     (user_word1),
		.user_data_valid(user_data_valid),
		.user_sync      (user_sync),
		.user_outofrange(user_outofrange)
	);

endmodule

`default_nettype wire

// File: tests/dual_adc_checker.sv
`timescale 1ns/1ns
`default_nettype none

module dual_adc_checker (
	input  wire                          dcm_psclk,
	input  wire                          ctrl_reset,
	input  wire                          adc0_locked,
	input  wire                          adc1_locked,
	input  wire                          adc1_reset,
	input  wire                          sample_req,
	input  wire                          sync_done,
	input  wire adc_sync_pkg::adc_word_t user_word0,
	input  wire adc_sync_pkg::adc_word_t user_word1,
	input  wire                          user_data_valid,
	input  wire                          user_sync,
	input  wire                          user_outofrange
);

	int                      errors = 0;
	int                      pairs_checked = 0;
	adc_sync_pkg::adc_word_t exp_word0_q[$];
	adc_sync_pkg::adc_word_t exp_word1_q[$];
	logic                    exp_sync_q[$];
	logic                    exp_oor_q[$];
	logic                    prev_done = 1'b0;
	logic                    prev_req = 1'b0;
	logic                    prev_locked = 1'b0;

	// Value compare, also used by the stimulus loop
	task automatic check_value(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		if (expected !== actual) begin
			errors++;
			$display("FAILED %s expected %h actual %h", name, expected, actual);
		end
	endtask

	task automatic report_problem(input string what);
		errors++;
		$display("ERROR: %s at %0t ns", what, $time);
	endtask

	task automatic push_pair(input adc_sync_pkg::adc_word_t w0, input adc_sync_pkg::adc_word_t w1,
		input logic s, input logic oor);
		exp_word0_q.push_back(w0);
		exp_word1_q.push_back(w1);
		exp_sync_q.push_back(s);
		exp_oor_q.push_back(oor);
	endtask

	// ============================================================
	// Protocol watch and pair compare
	// ============================================================
	always @(posedge dcm_psclk) begin
		if (!ctrl_reset) begin
			if (prev_done && !sync_done) report_problem("sync_done fell after calibration");
			if (prev_done && adc1_reset) report_problem("adc1_reset pulsed after sync_done");
			if (sample_req && !prev_req && !prev_locked) begin
				report_problem("sample_req rose before both locks were high");
			end
			if (user_data_valid && !sync_done) report_problem("pair released before sync_done");
			if (user_data_valid) begin
				if (exp_word0_q.size() == 0) begin
					report_problem("pair released with none expected");
				end else begin
					check_value($sformatf("pair%0d_word0", pairs_checked),
						exp_word0_q.pop_front(), user_word0);
					check_value($sformatf("pair%0d_word1", pairs_checked),
						exp_word1_q.pop_front(), user_word1);
					check_value($sformatf("pair%0d_sync", pairs_checked),
						exp_sync_q.pop_front(), user_sync);
					check_value($sformatf("pair%0d_outofrange", pairs_checked),
						exp_oor_q.pop_front(), user_outofrange);
					pairs_checked++;
				end
			end
		end
		prev_done   <= sync_done & ~ctrl_reset;
		prev_req    <= sample_req;
		prev_locked <= adc0_locked & adc1_locked;
	end

endmodule

`default_nettype wire

// File: tests/dual_adc_interface_tb.sv
`timescale 1ns/1ns
`default_nettype none

module dual_adc_interface_tb;

	localparam int STARTUP_CYCLES = 20;
	localparam int SETTLE_CYCLES  = 8;
	localparam int WAIT_LIMIT     = 200;	// Cycles allowed per wait
	localparam int NUM_PAIRS      = 40;
	localparam int NUM_ROWS       = 6;
	localparam int SAMPLE_MAX     = (1 << adc_sync_pkg::SAMPLE_W) - 1;

	typedef struct {
		string                     name;
		adc_sync_pkg::phase_bits_t phase;
		int                        lock_delay;
		adc_sync_pkg::reset_slot_t slot;
		logic                      done;
	} cal_row_t;

	typedef enum {watch_reset, watch_req, watch_done} watch_t;

	logic                      dcm_psclk = 1'b0;
	logic                      ctrl_reset;
	adc_sync_pkg::sample_t     d_ei[2], d_oi[2], d_eq[2], d_oq[2];
	logic                      d_sync[2], d_oor[2];
	logic                      adc0_locked, adc1_locked, clk_phase_valid;
	adc_sync_pkg::phase_bits_t clk_phase_bits;
	logic                      adc1_reset, sample_req, sync_done;
	adc_sync_pkg::reset_slot_t reset_slot;
	adc_sync_pkg::adc_word_t   user_word0, user_word1;
	logic                      user_data_valid, user_sync, user_outofrange;
	cal_row_t                  rows[NUM_ROWS];

	always #20 dcm_psclk = ~dcm_psclk;

	dual_adc_interface #(.STARTUP_CYCLES(STARTUP_CYCLES), .SETTLE_CYCLES(SETTLE_CYCLES))
	u_dual_adc_interface (
		.dcm_psclk(dcm_psclk), .ctrl_reset(ctrl_reset),
		.adc0_data_eveni(d_ei[0]), .adc0_data_oddi(d_oi[0]),
		.adc0_data_evenq(d_eq[0]), .adc0_data_oddq(d_oq[0]),
		.adc0_sync(d_sync[0]), .adc0_outofrange(d_oor[0]),
		.adc1_data_eveni(d_ei[1]), .adc1_data_oddi(d_oi[1]),
		.adc1_data_evenq(d_eq[1]), .adc1_data_oddq(d_oq[1]),
		.adc1_sync(d_sync[1]), .adc1_outofrange(d_oor[1]),
		.adc0_locked(adc0_locked), .adc1_locked(adc1_locked),
		.clk_phase_bits(clk_phase_bits), .clk_phase_valid(clk_phase_valid),
		.adc1_reset(adc1_reset), .reset_slot(reset_slot),
		.sample_req(sample_req), .sync_done(sync_done),
		.user_word0(user_word0), .user_word1(user_word1),
		.user_data_valid(user_data_valid), .user_sync(user_sync),
		.user_outofrange(user_outofrange)
	);

	dual_adc_checker u_checker (
		.dcm_psclk(dcm_psclk), .ctrl_reset(ctrl_reset),
		.adc0_locked(adc0_locked), .adc1_locked(adc1_locked),
		.adc1_reset(adc1_reset), .sample_req(sample_req), .sync_done(sync_done),
		.user_word0(user_word0), .user_word1(user_word1),
		.user_data_valid(user_data_valid), .user_sync(user_sync),
		.user_outofrange(user_outofrange)
	);

	task automatic stop_on_timeout(input string what);
		$display("Timeout while waiting for %s", what);
		$display("tests failed");
		$finish;
	endtask

	function automatic logic watched_level(input watch_t sel);
		case (sel)
			watch_reset: return adc1_reset;
			watch_req:   return sample_req;
			default:     return sync_done;
		endcase
	endfunction

	// Wait for a level seen at a rising edge
	task automatic wait_high(input watch_t sel, input string what);
		int n;
		n = 0;
		do begin
			@(posedge dcm_psclk);
			n++;
		end while (watched_level(sel) !== 1'b1 && n < WAIT_LIMIT);
		if (watched_level(sel) !== 1'b1) stop_on_timeout(what);
	endtask

	initial begin
		adc_sync_pkg::adc_word_t exp_w[2];
		adc_sync_pkg::sample_t   r[2][4];
		adc_sync_pkg::sample_t   f[2][4];
		logic                    sync_r[2], oor_r[2], oor_f[2];
		logic                    sync_any, oor_any;
		int                      n;

		void'($urandom(76435));
		rows[0] = '{"slot0_lacks_90", 4'b1101, 3, 2'd0, 1'b0};
		rows[1] = '{"slot1_only_90", 4'b0011, 0, 2'd1, 1'b0};
		rows[2] = '{"slot2_no_bits", 4'b0000, 5, 2'd2, 1'b0};
		rows[3] = '{"slot3_only_180", 4'b0101, 2, 2'd3, 1'b0};
		rows[4] = '{"slot0_wrapped", 4'b1001, 1, 2'd0, 1'b0};
		rows[5] = '{"slot1_aligned", 4'b0110, 4, 2'd1, 1'b1};
		ctrl_reset = 1'b1;
		adc0_locked = 1'b0;
		adc1_locked = 1'b0;
		clk_phase_bits = '0;
		clk_phase_valid = 1'b0;
		for (int l = 0; l < 2; l++) begin
			d_ei[l] = '0;
			d_oi[l] = '0;
			d_eq[l] = '0;
			d_oq[l] = '0;
			d_sync[l] = 1'b1;	// Held sync keeps the lanes idle
			d_oor[l] = 1'b0;
		end
		repeat (4) @(posedge dcm_psclk);
		ctrl_reset <= 1'b0;
		@(posedge dcm_psclk);
		u_checker.check_value("idle_adc1_reset", 0, adc1_reset);
		u_checker.check_value("idle_sample_req", 0, sample_req);
		u_checker.check_value("idle_sync_done", 0, sync_done);
		u_checker.check_value("idle_user_data_valid", 0, user_data_valid);
		u_checker.check_value("idle_reset_slot", 0, reset_slot);

		// ============================================================
		// Calibration table
		// ============================================================
		foreach (rows[i]) begin
			wait_high(watch_reset, {rows[i].name, " adc1_reset"});
			u_checker.check_value({rows[i].name, "_slot"}, rows[i].slot, reset_slot);
			adc0_locked <= 1'b0;
			adc1_locked <= 1'b0;
			for (int l = 0; l < 2; l++) begin
				d_sync[l] <= rows[i].done;	// Free-running lanes until the last attempt
			end
			repeat (SETTLE_CYCLES + rows[i].lock_delay) begin
				@(posedge dcm_psclk);
				u_checker.check_value({rows[i].name, "_gate"}, 0, sample_req);
			end
			adc0_locked <= 1'b1;	// One lock alone is not enough
			@(posedge dcm_psclk);
			u_checker.check_value({rows[i].name, "_gate"}, 0, sample_req);
			adc1_locked <= 1'b1;
			wait_high(watch_req, {rows[i].name, " sample_req"});
			clk_phase_bits  <= rows[i].phase;
			clk_phase_valid <= 1'b1;
			@(posedge dcm_psclk);
			clk_phase_valid <= 1'b0;
			if (rows[i].done) begin
				wait_high(watch_done, {rows[i].name, " sync_done"});
				repeat (30) @(posedge dcm_psclk);
				u_checker.check_value({rows[i].name, "_done_held"}, 1, sync_done);
			end
		end

		// ============================================================
		// Data pairs after calibration
		// ============================================================
		for (int k = 0; k < NUM_PAIRS; k++) begin
			sync_any = 1'b0;
			oor_any  = 1'b0;
			for (int l = 0; l < 2; l++) begin
				for (int s = 0; s < 4; s++) begin
					r[l][s] = adc_sync_pkg::sample_t'($urandom_range(SAMPLE_MAX));
					f[l][s] = adc_sync_pkg::sample_t'($urandom_range(SAMPLE_MAX));
				end
				// Held sync leaves the lanes expecting a fall half
				sync_r[l] = (k == 0) || (($urandom % 2) == 0);
				oor_r[l]  = ($urandom % 8) == 0;
				oor_f[l]  = ($urandom % 8) == 0;
				// i0 i1 from rise even/odd, i2 i3 from fall, q likewise
				exp_w[l] = {r[l][0], r[l][1], f[l][0], f[l][1],
					r[l][2], r[l][3], f[l][2], f[l][3]};
				sync_any = sync_any | sync_r[l];
				oor_any  = oor_any | oor_r[l] | oor_f[l];
			end
			u_checker.push_pair(exp_w[0], exp_w[1], sync_any, oor_any);
			for (int l = 0; l < 2; l++) begin
				d_ei[l]   <= r[l][0];	// Rise half
				d_oi[l]   <= r[l][1];
				d_eq[l]   <= r[l][2];
				d_oq[l]   <= r[l][3];
				d_sync[l] <= sync_r[l];
				d_oor[l]  <= oor_r[l];
			end
			@(posedge dcm_psclk);
			for (int l = 0; l < 2; l++) begin
				d_ei[l]   <= f[l][0];	// Fall half
				d_oi[l]   <= f[l][1];
				d_eq[l]   <= f[l][2];
				d_oq[l]   <= f[l][3];
				d_sync[l] <= 1'b0;
				d_oor[l]  <= oor_f[l];
			end
			@(posedge dcm_psclk);
		end
		for (int l = 0; l < 2; l++) begin
			d_sync[l] <= 1'b1;
			d_oor[l]  <= 1'b0;
		end

		n = 0;
		while (u_checker.pairs_checked < NUM_PAIRS && n < WAIT_LIMIT) begin
			@(posedge dcm_psclk);
			n++;
		end
		if (u_checker.pairs_checked < NUM_PAIRS) begin
			stop_on_timeout("the last data pair");
		end else begin
			repeat (4) @(posedge dcm_psclk);	// Room for a stray pair
			$display("Checks done: %0d pairs compared, %0d errors",
				u_checker.pairs_checked, u_checker.errors);
			if (u_checker.errors == 0) begin
				$display("all tests passed");
			end else begin
				$display("tests failed");
			end
			$finish;
		end
	end

endmodule

`default_nettype wire
